// ==== include/cordic_params.svh ====
`ifndef CORDIC_PARAMS_SVH
`define CORDIC_PARAMS_SVH

// data path width, Q16.16
`define CORDIC_WIDTH 32

// fraction bits of every fixed-point value
`define CORDIC_FRAC_BITS 16

// micro-rotations per operation
`define CORDIC_ITERATIONS 16

// entries in the request queue, also the initial credit count
`define CORDIC_FIFO_DEPTH 4

// 1/K for the circular gain, 0.607253 in Q16.16
`define CORDIC_K_INV 32'sd39797

// pi in Q16.16
`define CORDIC_PI 32'sd205887

// pi/2 in Q16.16
`define CORDIC_HALF_PI 32'sd102944

`endif

// ==== rtl/cordic_fixed_pkg.sv ====
`include "cordic_params.svh"

package cordic_fixed_pkg;

    // signed coordinate value, Q16.16
    typedef logic signed [`CORDIC_WIDTH-1:0] fixed_t;

    // signed angle in radians, Q16.16
    typedef logic signed [`CORDIC_WIDTH-1:0] angle_t;

    // micro-rotation index, also the shift amount
    typedef logic [$clog2(`CORDIC_ITERATIONS)-1:0] iter_t;

endpackage

// ==== rtl/cordic_flow_pkg.sv ====
`include "cordic_params.svh"

package cordic_flow_pkg;

    typedef enum logic {
        MODE_ROTATE = 1'b0,  // turn (x, y) by z
        MODE_VECTOR = 1'b1   // drive y to zero, accumulate angle in z
    } cordic_mode_e;

    typedef enum logic [1:0] {
        ENG_IDLE    = 2'd0,
        ENG_ITERATE = 2'd1,
        ENG_FINISH  = 2'd2
    } engine_state_e;

    // one folded request as it sits in the queue
    typedef struct packed {
        cordic_mode_e             mode;
        cordic_fixed_pkg::fixed_t x;
        cordic_fixed_pkg::fixed_t y;
        cordic_fixed_pkg::angle_t z;
        logic                     negate;  // rotation folded by pi, flip result
    } cordic_op_t;

    // credits held by the producer, 0 up to the queue depth
    typedef logic [$clog2(`CORDIC_FIFO_DEPTH+1)-1:0] credit_t;

endpackage

// ==== rtl/op_push_if.sv ====
`timescale 1ns/1ns

interface op_push_if;
    import cordic_flow_pkg::*;

    logic       push;           // one entry written this cycle
    cordic_op_t op;             // entry payload
    logic       credit_return;  // one slot freed in the queue

    modport producer (
        output push,
        output op,
        input  credit_return
    );

    modport queue (
        input  push,
        input  op,
        output credit_return
    );

endinterface

// ==== rtl/op_pop_if.sv ====
`timescale 1ns/1ns

interface op_pop_if;
    import cordic_flow_pkg::*;

    logic       not_empty;  // head holds a valid entry
    cordic_op_t head;       // oldest queued entry
    logic       pop;        // consume head on this edge

    modport queue (output not_empty, output head, input pop);

    modport engine (input not_empty, input head, output pop);

endinterface

// ==== rtl/quadrant_fold.sv ====
`timescale 1ns/1ns
`include "cordic_params.svh"

module quadrant_fold (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         req_valid,
    input  cordic_flow_pkg::cordic_mode_e req_mode,
    input  cordic_fixed_pkg::fixed_t     req_x,
    input  cordic_fixed_pkg::fixed_t     req_y,
    input  cordic_fixed_pkg::angle_t     req_z,
    output logic                         req_ready,
    op_push_if.producer                  push
);
    import cordic_fixed_pkg::*;
    import cordic_flow_pkg::*;

    localparam angle_t PI      = `CORDIC_PI;
    localparam angle_t HALF_PI = `CORDIC_HALF_PI;

    credit_t    credits;  // free queue slots not yet claimed
    logic       push_q;   // registered push, one cycle after accept
    cordic_op_t op_q;
    cordic_op_t folded;
    logic       accept;

    // a pending push has already claimed its slot
    assign req_ready = credits > credit_t'(push_q);
    assign accept    = req_valid && req_ready;

    // CORDIC converges for |z| <= ~1.74 rad and x >= 0 in vectoring
    always_comb begin
        folded.mode   = req_mode;
        folded.x      = req_x;
        folded.y      = req_y;
        folded.z      = req_z;
        folded.negate = 1'b0;
        if (req_mode == MODE_ROTATE) begin
            if (req_z > HALF_PI) begin
                folded.z      = req_z - PI;  // rotate by z - pi, then flip
                folded.negate = 1'b1;
            end else if (req_z < -HALF_PI) begin
                folded.z      = req_z + PI;
                folded.negate = 1'b1;
            end
        end else if (req_x[`CORDIC_WIDTH-1]) begin
            // mirror into the right half-plane, angle shifts by pi
            folded.x = -req_x;
            folded.y = -req_y;
            folded.z = req_y[`CORDIC_WIDTH-1] ? req_z - PI : req_z + PI;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            push_q  <= 1'b0;
            credits <= credit_t'(`CORDIC_FIFO_DEPTH);
        end else begin
            push_q  <= accept;
            credits <= credits - credit_t'(push_q) + credit_t'(push.credit_return);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q <= folded;
        end
    end

    assign push.push = push_q;
    assign push.op   = op_q;

endmodule

// ==== rtl/op_credit_fifo.sv ====
`timescale 1ns/1ns
`include "cordic_params.svh"

module op_credit_fifo (
    input  logic     clk,
    input  logic     rst,
    op_push_if.queue push,
    op_pop_if.queue  pop
);
    import cordic_flow_pkg::*;

    localparam int DEPTH = `CORDIC_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    cordic_op_t       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    credit_t          count;   // occupancy
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        next_ptr = (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign pop.not_empty = (count != '0);
    assign pop.head      = mem[rd_ptr];  // fall-through, head valid with not_empty
    assign do_pop        = pop.pop && (count != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr             <= '0;
            rd_ptr             <= '0;
            count              <= '0;
            push.credit_return <= 1'b0;
        end else begin
            if (push.push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count              <= count + credit_t'(push.push) - credit_t'(do_pop);
            push.credit_return <= do_pop;  // slot handed back one cycle after pop
        end
    end

    // producer never pushes without a credit, so no full check here
    always_ff @(posedge clk) begin
        if (push.push) begin
            mem[wr_ptr] <= push.op;
        end
    end

endmodule

// ==== rtl/cordic_engine.sv ====
`timescale 1ns/1ns
`include "cordic_params.svh"

module cordic_engine (
    input  logic                     clk,
    input  logic                     rst,
    op_pop_if.engine                 pop,
    output logic                     res_valid,
    output cordic_fixed_pkg::fixed_t res_x,
    output cordic_fixed_pkg::fixed_t res_y,
    output cordic_fixed_pkg::angle_t res_z
);
    import cordic_fixed_pkg::*;
    import cordic_flow_pkg::*;

    localparam int     FRAC      = `CORDIC_FRAC_BITS;
    localparam iter_t  LAST_ITER = iter_t'(`CORDIC_ITERATIONS - 1);
    localparam fixed_t K_INV     = `CORDIC_K_INV;

    engine_state_e state;
    iter_t         iter;
    logic          take;      // pop and load on this edge

    cordic_mode_e  mode_r;
    logic          negate_r;
    fixed_t        x_r;
    fixed_t        y_r;
    angle_t        z_r;

    fixed_t        shift_x;
    fixed_t        shift_y;
    angle_t        alpha;
    logic          sigma;     // 1 rotates counter-clockwise

    logic signed [2*`CORDIC_WIDTH-1:0] prod_x;
    logic signed [2*`CORDIC_WIDTH-1:0] prod_y;

    logic          fin_valid; // gain-corrected values ready
    fixed_t        scale_x;
    fixed_t        scale_y;
    angle_t        z_fin;
    logic          negate_fin;

    // atan(2^-i) in Q16.16
    function automatic angle_t atan_lut(input iter_t idx);
        case (idx)
            4'd0:    atan_lut = 32'sd51472;
            4'd1:    atan_lut = 32'sd30386;
            4'd2:    atan_lut = 32'sd16055;
            4'd3:    atan_lut = 32'sd8150;
            4'd4:    atan_lut = 32'sd4090;
            4'd5:    atan_lut = 32'sd2047;
            4'd6:    atan_lut = 32'sd1023;
            4'd7:    atan_lut = 32'sd511;
            4'd8:    atan_lut = 32'sd255;
            4'd9:    atan_lut = 32'sd127;
            4'd10:   atan_lut = 32'sd63;
            4'd11:   atan_lut = 32'sd31;
            4'd12:   atan_lut = 32'sd15;
            4'd13:   atan_lut = 32'sd7;
            4'd14:   atan_lut = 32'sd3;
            default: atan_lut = 32'sd1;
        endcase
    endfunction

    // the finish cycle may already pick up the next entry
    assign take    = pop.not_empty && (state == ENG_IDLE || state == ENG_FINISH);
    assign pop.pop = take;

    assign shift_x = x_r >>> iter;
    assign shift_y = y_r >>> iter;
    assign alpha   = atan_lut(iter);

    // rotation drives z to zero, vectoring drives y to zero
    assign sigma = (mode_r == MODE_ROTATE) ? ~z_r[`CORDIC_WIDTH-1]
                                           : (y_r[`CORDIC_WIDTH-1] != x_r[`CORDIC_WIDTH-1]);

    assign prod_x = x_r * K_INV;
    assign prod_y = y_r * K_INV;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ENG_IDLE;
            iter  <= '0;
        end else begin
            case (state)
                ENG_IDLE: begin
                    iter <= '0;
                    if (take) begin
                        state <= ENG_ITERATE;
                    end
                end
                ENG_ITERATE: begin
                    iter <= iter + 1'b1;
                    if (iter == LAST_ITER) begin
                        state <= ENG_FINISH;
                    end
                end
                ENG_FINISH: begin
                    iter  <= '0;
                    state <= take ? ENG_ITERATE : ENG_IDLE;
                end
                default: state <= ENG_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            mode_r   <= pop.head.mode;
            negate_r <= pop.head.negate;
            x_r      <= pop.head.x;
            y_r      <= pop.head.y;
            z_r      <= pop.head.z;
        end else if (state == ENG_ITERATE) begin
            x_r <= sigma ? x_r - shift_y : x_r + shift_y;
            y_r <= sigma ? y_r + shift_x : y_r - shift_x;
            z_r <= sigma ? z_r - alpha : z_r + alpha;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fin_valid <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            fin_valid <= (state == ENG_FINISH);
            res_valid <= fin_valid;  // single pulse, FINISH lasts one cycle
        end
    end

    // gain correction, then the fold flip on the output stage
    always_ff @(posedge clk) begin
        if (state == ENG_FINISH) begin
            scale_x    <= fixed_t'(prod_x >>> FRAC);
            scale_y    <= fixed_t'(prod_y >>> FRAC);
            z_fin      <= z_r;
            negate_fin <= negate_r;
        end
        if (fin_valid) begin
            res_x <= negate_fin ? -scale_x : scale_x;
            res_y <= negate_fin ? -scale_y : scale_y;
            res_z <= z_fin;
        end
    end

endmodule

// ==== rtl/cordic_top.sv ====
`timescale 1ns/1ns

module cordic_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req_valid,
    input  cordic_flow_pkg::cordic_mode_e req_mode,
    input  cordic_fixed_pkg::fixed_t      req_x,
    input  cordic_fixed_pkg::fixed_t      req_y,
    input  cordic_fixed_pkg::angle_t      req_z,
    output logic                          req_ready,
    output logic                          res_valid,
    output cordic_fixed_pkg::fixed_t      res_x,
    output cordic_fixed_pkg::fixed_t      res_y,
    output cordic_fixed_pkg::angle_t      res_z
);

    op_push_if push_bus ();  // producer to queue, credits back
    op_pop_if  pop_bus ();   // queue head to engine

    quadrant_fold u_fold (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_mode  (req_mode),
        .req_x     (req_x),
        .req_y     (req_y),
        .req_z     (req_z),
        .req_ready (req_ready),
        .push      (push_bus)
    );

    op_credit_fifo u_queue (
        .clk  (clk),
        .rst  (rst),
        .push (push_bus),
        .pop  (pop_bus)
    );

    cordic_engine u_engine (
        .clk       (clk),
        .rst       (rst),
        .pop       (pop_bus),
        .res_valid (res_valid),
        .res_x     (res_x),
        .res_y     (res_y),
        .res_z     (res_z)
    );

endmodule

// ==== tests/cordic_properties.sv ====
`timescale 1ns/1ns
`include "cordic_params.svh"

module cordic_properties (
    input logic                     clk,
    input logic                     rst,
    input logic                     push,
    input logic                     pop,
    input logic                     res_valid,
    input cordic_flow_pkg::credit_t credits,  // producer side
    input cordic_flow_pkg::credit_t count     // queue occupancy
);

    queue_bound: assert property (@(posedge clk) disable iff (rst)
        count <= `CORDIC_FIFO_DEPTH)
        else $error("queue occupancy %0d above depth", count);

    push_has_credit: assert property (@(posedge clk) disable iff (rst)
        push |-> credits != 0)
        else $error("push issued while the producer held no credit");

    res_single_pulse: assert property (@(posedge clk) disable iff (rst)
        res_valid |=> !res_valid)
        else $error("res_valid high for two cycles in a row");

    // set on the 18th edge after the pop, seen at the following sample
    pop_to_result: assert property (@(posedge clk) disable iff (rst)
        pop |-> ##19 $rose(res_valid))
        else $error("res_valid did not rise 18 cycles after a pop");

endmodule

bind cordic_top cordic_properties u_props (
    .clk       (clk),
    .rst       (rst),
    .push      (push_bus.push),
    .pop       (pop_bus.pop),
    .res_valid (res_valid),
    .credits   (u_fold.credits),
    .count     (u_queue.count)
);

// ==== tests/cordic_tb.sv ====
`timescale 1ns/1ns
`include "cordic_params.svh"

module cordic_tb;
    import cordic_fixed_pkg::*;
    import cordic_flow_pkg::*;

    localparam int  N_PER_TEST = 20;
    localparam int  N_TOTAL    = 5 * N_PER_TEST;
    localparam int  TIMEOUT_NS = N_TOTAL * 25 * 40 + 16 * 40;  // requests plus reset
    localparam int  TOL_LSB    = 48;
    localparam int  XY_LIM     = 98304;  // 1.5
    localparam int  X_MIN      = 16384;  // 0.25, keeps atan2 well conditioned
    localparam real SCALE      = 65536.0;
    localparam real PI_R       = 3.14159265358979;

    typedef struct packed {
        cordic_mode_e mode;
        int           x;
        int           y;
        int           z;
        int           id;  // test the request belongs to
    } req_t;

    logic         clk = 1'b0;
    logic         rst;
    logic         req_valid;
    cordic_mode_e req_mode;
    fixed_t       req_x;
    fixed_t       req_y;
    angle_t       req_z;
    logic         req_ready;
    logic         res_valid;
    fixed_t       res_x;
    fixed_t       res_y;
    angle_t       res_z;

    int    seed;
    int    cur_test;
    int    checks [6];
    int    errors [6];
    int    total_checks;
    int    total_errors;
    req_t  pending [$];  // accepted requests, oldest first
    string names [6] = '{"after_reset", "rotate_small", "rotate_large",
                         "vector_pos", "vector_neg", "backpressure"};

    cordic_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_mode  (req_mode),
        .req_x     (req_x),
        .req_y     (req_y),
        .req_z     (req_z),
        .req_ready (req_ready),
        .res_valid (res_valid),
        .res_x     (res_x),
        .res_y     (res_y),
        .res_z     (res_z)
    );

    always #20 clk = ~clk;

    function automatic int rand_below(input int n);
        rand_below = int'($unsigned($random(seed)) % n);
    endfunction

    function automatic int rand_range(input int lim);
        rand_range = rand_below(2 * lim + 1) - lim;
    endfunction

    // kinds 1..4 pick small rotation, large rotation, vectoring x > 0, vectoring x < 0
    function automatic req_t make_request(input int kind, input int id);
        req_t r;
        int   mag;
        r.id   = id;
        r.mode = (kind <= 2) ? MODE_ROTATE : MODE_VECTOR;
        r.x    = rand_range(XY_LIM);
        r.y    = rand_range(XY_LIM);
        r.z    = rand_range(`CORDIC_PI);
        mag    = `CORDIC_HALF_PI + 1 + rand_below(`CORDIC_PI - `CORDIC_HALF_PI);
        case (kind)
            1:       r.z = rand_range(`CORDIC_HALF_PI);
            2:       r.z = rand_below(2) ? mag : -mag;
            3:       r.x = X_MIN + rand_below(XY_LIM - X_MIN + 1);
            default: r.x = -(X_MIN + rand_below(XY_LIM - X_MIN + 1));
        endcase
        return r;
    endfunction

    task automatic check_field(input int id, input string what, input real exp_r,
                               input int act, input bit wrap);
        real d;
        d = $itor(act) / SCALE - exp_r;
        while (wrap && d > PI_R)
            d = d - 2.0 * PI_R;
        while (wrap && d < -PI_R)
            d = d + 2.0 * PI_R;
        checks[id]++;
        assert (d * SCALE <= TOL_LSB && d * SCALE >= -TOL_LSB) else begin
            $display("FAIL %s %s expected %0d actual %0d", names[id], what,
                     $rtoi(exp_r * SCALE), act);
            errors[id]++;
        end
    endtask

    always @(negedge clk) begin : result_monitor
        req_t item;
        real  xr;
        real  yr;
        real  zr;
        if (!rst && res_valid) begin
            if (pending.size() == 0) begin
                $display("result appeared with no request outstanding in %s", names[cur_test]);
                errors[cur_test]++;
            end else begin
                item = pending.pop_front();
                xr   = $itor(item.x) / SCALE;
                yr   = $itor(item.y) / SCALE;
                zr   = $itor(item.z) / SCALE;
                if (item.mode == MODE_ROTATE) begin
                    check_field(item.id, "res_x", xr * $cos(zr) - yr * $sin(zr), res_x, 1'b0);
                    check_field(item.id, "res_y", xr * $sin(zr) + yr * $cos(zr), res_y, 1'b0);
                    check_field(item.id, "res_z", 0.0, res_z, 1'b1);
                end else begin
                    check_field(item.id, "res_x", $sqrt(xr * xr + yr * yr), res_x, 1'b0);
                    check_field(item.id, "res_y", 0.0, res_y, 1'b0);
                    check_field(item.id, "res_z", zr + $atan2(yr, xr), res_z, 1'b1);
                end
            end
        end
    end

    // returns once the request is accepted on the coming rising edge
    task automatic send_request(input req_t item, output int waits);
        waits = 0;
        @(negedge clk);
        req_valid = 1'b1;
        req_mode  = item.mode;
        req_x     = item.x;
        req_y     = item.y;
        req_z     = item.z;
        while (!req_ready) begin
            waits++;
            @(negedge clk);
        end
        pending.push_back(item);
    endtask

    task automatic run_test(input int id);
        int waits;
        int first_stall;  // requests accepted before the first stall
        first_stall = -1;
        cur_test    = id;
        for (int i = 0; i < N_PER_TEST; i++) begin
            send_request(make_request(id == 5 ? 1 + rand_below(4) : id, id), waits);
            if (waits > 0 && first_stall < 0)
                first_stall = i;
            if (id != 5 && rand_below(3) == 0) begin
                @(negedge clk);
                req_valid = 1'b0;
                repeat (rand_below(5)) @(negedge clk);
            end
        end
        @(negedge clk);
        req_valid = 1'b0;
        while (pending.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);  // room for a stray extra result
        if (id == 5) begin
            checks[id] += 2;
            assert (first_stall >= 0) else begin
                $display("req_ready never fell while req_valid was held high");
                errors[id]++;
            end
            // four queued or in flight, plus the one already in the engine
            assert (first_stall < 0 || (first_stall >= `CORDIC_FIFO_DEPTH &&
                    first_stall <= `CORDIC_FIFO_DEPTH + 1)) else begin
                $display("FAIL %s accepted before stall expected %0d to %0d actual %0d",
                         names[id], `CORDIC_FIFO_DEPTH, `CORDIC_FIFO_DEPTH + 1, first_stall);
                errors[id]++;
            end
        end
        $display("%s: %0d checks, %0d errors", names[id], checks[id], errors[id]);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("timeout after %0d ns with %0d results outstanding", TIMEOUT_NS, pending.size());
        $display("Test failed");
        $finish;
    end

    initial begin
        seed      = 32'hea53b19d;
        cur_test  = 0;
        rst       = 1'b1;
        req_valid = 1'b0;
        req_mode  = MODE_ROTATE;
        req_x     = '0;
        req_y     = '0;
        req_z     = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        checks[0] = 2;
        assert (res_valid === 1'b0) else begin
            $display("FAIL %s res_valid expected 0 actual %b", names[0], res_valid);
            errors[0]++;
        end
        assert (req_ready === 1'b1) else begin
            $display("FAIL %s req_ready expected 1 actual %b", names[0], req_ready);
            errors[0]++;
        end
        $display("%s: %0d checks, %0d errors", names[0], checks[0], errors[0]);
        for (int id = 1; id <= 5; id++)
            run_test(id);
        total_checks = 0;
        total_errors = 0;
        for (int id = 0; id < 6; id++) begin
            total_checks += checks[id];
            total_errors += errors[id];
        end
        $display("tests 6, checks %0d, errors %0d", total_checks, total_errors);
        if (total_errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+include
rtl/cordic_fixed_pkg.sv
rtl/cordic_flow_pkg.sv
rtl/op_push_if.sv
rtl/op_pop_if.sv
rtl/quadrant_fold.sv
rtl/op_credit_fifo.sv
rtl/cordic_engine.sv
rtl/cordic_top.sv
tests/cordic_properties.sv
tests/cordic_tb.sv
